// ==== common/dbg_pkg.sv ====
// ----------------------------------------
// Shared widths, codes and register map of the debug
// transport. DMI scan word is {addr, data, op}, op at bit 0.
// ----------------------------------------
`default_nettype none

package dbg_pkg;

    // Data and scan widths
    localparam int XLEN       = 32;
    localparam int DMI_ADDR_W = 7;
    localparam int DMI_DATA_W = 32;
    localparam int DMI_OP_W   = 2;
    localparam int DMI_DR_W   = DMI_ADDR_W + DMI_DATA_W + DMI_OP_W;

    // Field positions inside the DMI scan register
    localparam int DMI_DATA_LSB = DMI_OP_W;
    localparam int DMI_ADDR_LSB = DMI_OP_W + DMI_DATA_W;

    // Instruction register
    localparam int              IR_W      = 5;
    localparam logic [IR_W-1:0] IR_IDCODE = 5'h01;
    localparam logic [IR_W-1:0] IR_DMI    = 5'h11;
    localparam logic [IR_W-1:0] IR_BYPASS = 5'h1f;

    // Core reset stretch, in clk cycles
    localparam int CORE_RST_HOLD = 4;
    localparam int RST_CNT_W     = $clog2(CORE_RST_HOLD + 1);

    // ----------------------------------------
    // Debug module register map
    // ----------------------------------------
    localparam logic [DMI_ADDR_W-1:0] DM_DATA0_ADDR     = 7'h04;
    localparam logic [DMI_ADDR_W-1:0] DM_DMCONTROL_ADDR = 7'h10;
    localparam logic [DMI_ADDR_W-1:0] DM_DMSTATUS_ADDR  = 7'h11;
    localparam logic [DMI_ADDR_W-1:0] DM_HARTID_ADDR    = 7'h12;

    // Version 2 in [3:0], authenticated at bit 7
    localparam logic [DMI_DATA_W-1:0] DMSTATUS_VALUE = 32'h0000_0082;

    typedef enum logic [3:0] {
        TAP_RESET, TAP_IDLE,
        TAP_SEL_DR, TAP_CAP_DR, TAP_SHIFT_DR, TAP_EXIT1_DR,
        TAP_PAUSE_DR, TAP_EXIT2_DR, TAP_UPD_DR,
        TAP_SEL_IR, TAP_CAP_IR, TAP_SHIFT_IR, TAP_EXIT1_IR,
        TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPD_IR
    } tap_state_e;

    // Request op on update, status on capture
    typedef enum logic [DMI_OP_W-1:0] {
        DMI_OP_NOP   = 2'd0,
        DMI_OP_READ  = 2'd1,
        DMI_OP_WRITE = 2'd2,
        DMI_OP_BUSY  = 2'd3
    } dmi_op_e;

    localparam dmi_op_e DMI_STATUS_OK   = DMI_OP_NOP;
    localparam dmi_op_e DMI_STATUS_BUSY = DMI_OP_BUSY;

endpackage : dbg_pkg

`default_nettype wire

// ==== common/dmi_if.sv ====
// ----------------------------------------
// DMI request/response channel. One request outstanding;
// resp is a single-cycle pulse with rdata valid.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface dmi_if;

    logic                            req;
    logic                            wr;
    logic [dbg_pkg::DMI_ADDR_W-1:0]  addr;
    logic [dbg_pkg::DMI_DATA_W-1:0]  wdata;
    logic                            resp;
    logic [dbg_pkg::DMI_DATA_W-1:0]  rdata;

    modport requester (output req, wr, addr, wdata, input resp, rdata);
    modport responder (input req, wr, addr, wdata, output resp, rdata);

endinterface : dmi_if

`default_nettype wire

// ==== tapc/jtag_sampler.sv ====
// ----------------------------------------
// JTAG pins are oversampled by clk. tck must stay below
// clk/6; strobes appear 3 clk cycles after the pin edge.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module jtag_sampler (
    input  logic clk,
    input  logic i_rst,
    input  logic i_tck,
    input  logic i_tms,
    input  logic i_tdi,
    output logic o_tck_rise,
    output logic o_tck_fall,
    output logic o_tms,
    output logic o_tdi
);

// Two sync stages plus one for edge detection
logic [2:0] tck_sync;
logic [2:0] tms_sync;
logic [2:0] tdi_sync;

always_ff @(posedge clk)
begin
    if (i_rst)
    begin
        tck_sync   <= '0;
        tms_sync   <= '0;
        tdi_sync   <= '0;
        o_tck_rise <= 1'b0;
        o_tck_fall <= 1'b0;
    end
    else
    begin
        tck_sync   <= {tck_sync[1:0], i_tck};
        tms_sync   <= {tms_sync[1:0], i_tms};
        tdi_sync   <= {tdi_sync[1:0], i_tdi};
        o_tck_rise <= tck_sync[1] & ~tck_sync[2];
        o_tck_fall <= ~tck_sync[1] & tck_sync[2];
    end
end

// Third stage lines tms and tdi up with the strobes
assign o_tms = tms_sync[2];
assign o_tdi = tdi_sync[2];

endmodule : jtag_sampler

`default_nettype wire

// ==== tapc/tap_ctrl.sv ====
// ----------------------------------------
// TAP controller run on tck strobes from the clk domain.
// Unknown IR codes select BYPASS. Busy status is sticky
// until a DMI capture with no request outstanding.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tap_ctrl (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_tck_rise,
    input  logic                     i_tck_fall,
    input  logic                     i_tms,
    input  logic                     i_tdi,
    input  logic [dbg_pkg::XLEN-1:0] i_fuse_idcode,
    output logic                     o_tdo,
    output logic                     o_tdo_en,
    dmi_if.requester                 dmi
);

dbg_pkg::tap_state_e                state;
dbg_pkg::tap_state_e                state_next;
logic [dbg_pkg::IR_W-1:0]           ir_sh;
logic [dbg_pkg::IR_W-1:0]           ir_reg;
logic [dbg_pkg::XLEN-1:0]           idcode_sh;
logic                               bypass_sh;
logic [dbg_pkg::DMI_DR_W-1:0]       dmi_sh;
logic                               dr_tdo;
logic                               sel_dmi;
dbg_pkg::dmi_op_e                   upd_op;
dbg_pkg::dmi_op_e                   cap_status;
logic                               req_q;
logic                               wr_q;
logic [dbg_pkg::DMI_ADDR_W-1:0]     addr_q;
logic [dbg_pkg::DMI_DATA_W-1:0]     wdata_q;
logic [dbg_pkg::DMI_DATA_W-1:0]     rdata_q;
logic                               busy_sticky;

// ----------------------------------------
// TAP state machine
// ----------------------------------------
always_comb
begin
    case (state)
        dbg_pkg::TAP_RESET:    state_next = i_tms ? dbg_pkg::TAP_RESET    : dbg_pkg::TAP_IDLE;
        dbg_pkg::TAP_IDLE:     state_next = i_tms ? dbg_pkg::TAP_SEL_DR   : dbg_pkg::TAP_IDLE;
        dbg_pkg::TAP_SEL_DR:   state_next = i_tms ? dbg_pkg::TAP_SEL_IR   : dbg_pkg::TAP_CAP_DR;
        dbg_pkg::TAP_CAP_DR:   state_next = i_tms ? dbg_pkg::TAP_EXIT1_DR : dbg_pkg::TAP_SHIFT_DR;
        dbg_pkg::TAP_SHIFT_DR: state_next = i_tms ? dbg_pkg::TAP_EXIT1_DR : dbg_pkg::TAP_SHIFT_DR;
        dbg_pkg::TAP_EXIT1_DR: state_next = i_tms ? dbg_pkg::TAP_UPD_DR   : dbg_pkg::TAP_PAUSE_DR;
        dbg_pkg::TAP_PAUSE_DR: state_next = i_tms ? dbg_pkg::TAP_EXIT2_DR : dbg_pkg::TAP_PAUSE_DR;
        dbg_pkg::TAP_EXIT2_DR: state_next = i_tms ? dbg_pkg::TAP_UPD_DR   : dbg_pkg::TAP_SHIFT_DR;
        dbg_pkg::TAP_UPD_DR:   state_next = i_tms ? dbg_pkg::TAP_SEL_DR   : dbg_pkg::TAP_IDLE;
        dbg_pkg::TAP_SEL_IR:   state_next = i_tms ? dbg_pkg::TAP_RESET    : dbg_pkg::TAP_CAP_IR;
        dbg_pkg::TAP_CAP_IR:   state_next = i_tms ? dbg_pkg::TAP_EXIT1_IR : dbg_pkg::TAP_SHIFT_IR;
        dbg_pkg::TAP_SHIFT_IR: state_next = i_tms ? dbg_pkg::TAP_EXIT1_IR : dbg_pkg::TAP_SHIFT_IR;
        dbg_pkg::TAP_EXIT1_IR: state_next = i_tms ? dbg_pkg::TAP_UPD_IR   : dbg_pkg::TAP_PAUSE_IR;
        dbg_pkg::TAP_PAUSE_IR: state_next = i_tms ? dbg_pkg::TAP_EXIT2_IR : dbg_pkg::TAP_PAUSE_IR;
        dbg_pkg::TAP_EXIT2_IR: state_next = i_tms ? dbg_pkg::TAP_UPD_IR   : dbg_pkg::TAP_SHIFT_IR;
        dbg_pkg::TAP_UPD_IR:   state_next = i_tms ? dbg_pkg::TAP_SEL_DR   : dbg_pkg::TAP_IDLE;
        default:               state_next = dbg_pkg::TAP_RESET;
    endcase
end

always_ff @(posedge clk)
begin
    if (i_rst)
        state <= dbg_pkg::TAP_RESET;
    else if (i_tck_rise)
        state <= state_next;
end

// ----------------------------------------
// Instruction register
// ----------------------------------------
always_ff @(posedge clk)
begin
    if (i_rst)
    begin
        ir_sh  <= '0;
        ir_reg <= dbg_pkg::IR_IDCODE;
    end
    else
    begin
        if (state == dbg_pkg::TAP_RESET)
            ir_reg <= dbg_pkg::IR_IDCODE;
        else if (i_tck_fall && state == dbg_pkg::TAP_UPD_IR)
            ir_reg <= ir_sh;
        if (i_tck_rise && state == dbg_pkg::TAP_CAP_IR)
            ir_sh <= dbg_pkg::IR_W'(1);
        else if (i_tck_rise && state == dbg_pkg::TAP_SHIFT_IR)
            ir_sh <= {i_tdi, ir_sh[dbg_pkg::IR_W-1:1]};
    end
end

assign sel_dmi = (ir_reg == dbg_pkg::IR_DMI);

// ----------------------------------------
// Data registers, shifted LSB first
// ----------------------------------------
assign cap_status = (busy_sticky || req_q) ? dbg_pkg::DMI_STATUS_BUSY
                                           : dbg_pkg::DMI_STATUS_OK;

always_ff @(posedge clk)
begin
    if (i_tck_rise && state == dbg_pkg::TAP_CAP_DR)
    begin
        idcode_sh <= i_fuse_idcode;
        bypass_sh <= 1'b0;
        dmi_sh    <= {addr_q, rdata_q, cap_status};
    end
    else if (i_tck_rise && state == dbg_pkg::TAP_SHIFT_DR)
    begin
        idcode_sh <= {i_tdi, idcode_sh[dbg_pkg::XLEN-1:1]};
        bypass_sh <= i_tdi;
        dmi_sh    <= {i_tdi, dmi_sh[dbg_pkg::DMI_DR_W-1:1]};
    end
end

// IR_BYPASS and any unknown code fall to the bypass bit
always_comb
begin
    case (ir_reg)
        dbg_pkg::IR_IDCODE: dr_tdo = idcode_sh[0];
        dbg_pkg::IR_DMI:    dr_tdo = dmi_sh[0];
        default:            dr_tdo = bypass_sh;
    endcase
end

always_ff @(posedge clk)
begin
    if (i_rst)
        o_tdo <= 1'b0;
    else if (i_tck_fall && state == dbg_pkg::TAP_SHIFT_IR)
        o_tdo <= ir_sh[0];
    else if (i_tck_fall && state == dbg_pkg::TAP_SHIFT_DR)
        o_tdo <= dr_tdo;
end

assign o_tdo_en = (state == dbg_pkg::TAP_SHIFT_IR) || (state == dbg_pkg::TAP_SHIFT_DR);

// ----------------------------------------
// DMI requester
// ----------------------------------------
assign upd_op = dbg_pkg::dmi_op_e'(dmi_sh[dbg_pkg::DMI_OP_W-1:0]);

always_ff @(posedge clk)
begin
    if (i_rst)
    begin
        req_q       <= 1'b0;
        wr_q        <= 1'b0;
        addr_q      <= '0;
        busy_sticky <= 1'b0;
    end
    else
    begin
        if (dmi.resp)
            req_q <= 1'b0;
        // A clean capture clears the sticky busy
        if (i_tck_rise && sel_dmi && state == dbg_pkg::TAP_CAP_DR && !req_q)
            busy_sticky <= 1'b0;
        if (i_tck_fall && sel_dmi && state == dbg_pkg::TAP_UPD_DR &&
            (upd_op == dbg_pkg::DMI_OP_READ || upd_op == dbg_pkg::DMI_OP_WRITE))
        begin
            if (req_q)
                busy_sticky <= 1'b1;
            else
            begin
                req_q  <= 1'b1;
                wr_q   <= (upd_op == dbg_pkg::DMI_OP_WRITE);
                addr_q <= dmi_sh[dbg_pkg::DMI_ADDR_LSB +: dbg_pkg::DMI_ADDR_W];
            end
        end
    end
end

// Write data and last read data
always_ff @(posedge clk)
begin
    if (i_tck_fall && sel_dmi && state == dbg_pkg::TAP_UPD_DR && !req_q)
        wdata_q <= dmi_sh[dbg_pkg::DMI_DATA_LSB +: dbg_pkg::DMI_DATA_W];
    if (dmi.resp && !wr_q)
        rdata_q <= dmi.rdata;
end

assign dmi.req   = req_q;
assign dmi.wr    = wr_q;
assign dmi.addr  = addr_q;
assign dmi.wdata = wdata_q;

endmodule : tap_ctrl

`default_nettype wire

// ==== dm/debug_module.sv ====
// ----------------------------------------
// Minimal debug module: data0, dmcontrol, dmstatus and
// hart ID. Writes take effect one cycle after resp.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module debug_module (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic [dbg_pkg::XLEN-1:0] i_fuse_mhartid,
    output logic                     o_ndmreset,
    dmi_if.responder                 dmi
);

logic                             resp_q;
logic [dbg_pkg::DMI_DATA_W-1:0]   rdata_q;
logic [dbg_pkg::DMI_DATA_W-1:0]   rd_mux;
logic [dbg_pkg::DMI_DATA_W-1:0]   data0;
logic                             dmactive;
logic                             new_req;
logic                             wr_en;

// First cycle of a request; writes land while resp is high
assign new_req = dmi.req && !resp_q;
assign wr_en   = dmi.req && dmi.wr && resp_q;

// ----------------------------------------
// Read decode
// ----------------------------------------
always_comb
begin
    case (dmi.addr)
        dbg_pkg::DM_DATA0_ADDR:
            rd_mux = data0;
        dbg_pkg::DM_DMCONTROL_ADDR:
            rd_mux = {{(dbg_pkg::DMI_DATA_W-2){1'b0}}, o_ndmreset, dmactive};
        dbg_pkg::DM_DMSTATUS_ADDR:
            rd_mux = dbg_pkg::DMSTATUS_VALUE;
        dbg_pkg::DM_HARTID_ADDR:
            rd_mux = i_fuse_mhartid;
        // Unmapped space reads zero
        default:
            rd_mux = '0;
    endcase
end

// ----------------------------------------
// Response and registers
// ----------------------------------------
always_ff @(posedge clk)
begin
    if (i_rst)
        resp_q <= 1'b0;
    else
        resp_q <= new_req;
end

always_ff @(posedge clk)
begin
    if (new_req)
        rdata_q <= rd_mux;
    if (wr_en && dmi.addr == dbg_pkg::DM_DATA0_ADDR)
        data0 <= dmi.wdata;
end

always_ff @(posedge clk)
begin
    if (i_rst)
    begin
        dmactive   <= 1'b0;
        o_ndmreset <= 1'b0;
    end
    else if (wr_en && dmi.addr == dbg_pkg::DM_DMCONTROL_ADDR)
    begin
        dmactive   <= dmi.wdata[0];
        // ndmreset only sticks while dmactive is written 1
        o_ndmreset <= dmi.wdata[0] & dmi.wdata[1];
    end
end

assign dmi.resp  = resp_q;
assign dmi.rdata = rdata_q;

endmodule : debug_module

`default_nettype wire

// ==== hdl/reset_ctrl.sv ====
// ----------------------------------------
// All reset sources are synchronous to clk. Core reset
// follows any source at once and releases CORE_RST_HOLD
// cycles after the last one drops.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module reset_ctrl (
    input  logic clk,
    input  logic i_rst,
    input  logic i_sys_rst,
    input  logic i_cpu_rst,
    input  logic i_ndmreset,
    output logic o_core_rst
);

logic                           rst_any;
logic [dbg_pkg::RST_CNT_W-1:0]  hold_cnt;

assign rst_any = i_rst | i_sys_rst | i_cpu_rst | i_ndmreset;

// Reload while any source is active, then count down
always_ff @(posedge clk)
begin
    if (rst_any)
        hold_cnt <= dbg_pkg::RST_CNT_W'(dbg_pkg::CORE_RST_HOLD);
    else if (hold_cnt != '0)
        hold_cnt <= hold_cnt - 1'b1;
end

assign o_core_rst = rst_any | (hold_cnt != '0);

endmodule : reset_ctrl

`default_nettype wire

// ==== hdl/core_top.sv ====
// ----------------------------------------
// Reset and debug transport top. Single clk domain; the
// JTAG pins are oversampled, so tck must be slow.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_top (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_sys_rst,
    input  logic                     i_cpu_rst,
    input  logic [dbg_pkg::XLEN-1:0] i_fuse_mhartid,
    input  logic [dbg_pkg::XLEN-1:0] i_fuse_idcode,
    input  logic                     i_tck,
    input  logic                     i_tms,
    input  logic                     i_tdi,
    output logic                     o_tdo,
    output logic                     o_tdo_en,
    output logic                     o_core_rst,
    output logic                     o_ndm_rst
);

logic tck_rise;
logic tck_fall;
logic tms_s;
logic tdi_s;
logic ndmreset;

dmi_if dmi_bus ();

// ----------------------------------------
// JTAG transport
// ----------------------------------------
jtag_sampler i_jtag_sampler (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_tck      (i_tck),
    .i_tms      (i_tms),
    .i_tdi      (i_tdi),
    .o_tck_rise (tck_rise),
    .o_tck_fall (tck_fall),
    .o_tms      (tms_s),
    .o_tdi      (tdi_s)
);

tap_ctrl i_tap_ctrl (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_tck_rise    (tck_rise),
    .i_tck_fall    (tck_fall),
    .i_tms         (tms_s),
    .i_tdi         (tdi_s),
    .i_fuse_idcode (i_fuse_idcode),
    .o_tdo         (o_tdo),
    .o_tdo_en      (o_tdo_en),
    .dmi           (dmi_bus.requester)
);

// ----------------------------------------
// Debug module and resets
// ----------------------------------------
debug_module i_debug_module (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_fuse_mhartid (i_fuse_mhartid),
    .o_ndmreset     (ndmreset),
    .dmi            (dmi_bus.responder)
);

reset_ctrl i_reset_ctrl (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_sys_rst  (i_sys_rst),
    .i_cpu_rst  (i_cpu_rst),
    .i_ndmreset (ndmreset),
    .o_core_rst (o_core_rst)
);

assign o_ndm_rst = ndmreset;

endmodule : core_top

`default_nettype wire

// ==== verif/core_top_asserts.sv ====
// ----------------------------------------
// SVA checks on the DMI handshake and the tdo enable,
// bound into core_top. All checks are idle during i_rst.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_top_asserts (
    input logic                clk,
    input logic                i_rst,
    input logic                i_req,
    input logic                i_resp,
    input logic                i_tdo_en,
    input dbg_pkg::tap_state_e i_tap_state
);

// Failures so far, summed up by the testbench
int fail_cnt = 0;

// Request stays up until the debug module answers
req_hold_a : assert property (@(posedge clk) disable iff (i_rst)
    i_req && !i_resp |=> i_req)
    else
    begin
        fail_cnt++;
        $error("DMI req dropped before resp");
    end

// Single-cycle resp, only inside a request, req gone afterwards
resp_pulse_a : assert property (@(posedge clk) disable iff (i_rst)
    i_resp |-> i_req ##1 (!i_resp && !i_req))
    else
    begin
        fail_cnt++;
        $error("DMI resp is not a one-cycle pulse closing the request");
    end

tdo_en_a : assert property (@(posedge clk) disable iff (i_rst)
    i_tdo_en |-> (i_tap_state == dbg_pkg::TAP_SHIFT_IR ||
                  i_tap_state == dbg_pkg::TAP_SHIFT_DR))
    else
    begin
        fail_cnt++;
        $error("o_tdo_en high outside Shift-IR and Shift-DR");
    end

endmodule : core_top_asserts

bind core_top core_top_asserts i_core_top_asserts (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_req       (dmi_bus.req),
    .i_resp      (dmi_bus.resp),
    .i_tdo_en    (o_tdo_en),
    .i_tap_state (i_tap_ctrl.state)
);

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
// ----------------------------------------
// Free-running testbench clock, 100 ns period.
// Starts low, so the first rising edge is at 50 ns.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic o_clk
);

localparam int HALF_PERIOD = 50;

initial
begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
end

endmodule : tb_clkgen

`default_nettype wire

// ==== verif/tb_core_top.sv ====
// ----------------------------------------
// Testbench for core_top. JTAG runs at clk/8 and DMI
// results are polled through NOP scans. Inputs change
// 10 ns after the rising clk edge.
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_core_top;

localparam int          DRIVE_DELAY   = 10;
localparam int          TCK_HALF      = 4;
localparam int          POLL_LIMIT    = 8;
localparam int          RST_LIMIT     = 20;
localparam int          NDM_LIMIT     = 2000;
localparam logic [31:0] SEED          = 32'hfa0b;
localparam logic [dbg_pkg::DMI_ADDR_W-1:0] UNMAPPED_ADDR = 7'h20;

logic                     clk;
logic                     rst;
logic                     sys_rst;
logic                     cpu_rst;
logic [dbg_pkg::XLEN-1:0] fuse_mhartid;
logic [dbg_pkg::XLEN-1:0] fuse_idcode;
logic                     tck;
logic                     tms;
logic                     tdi;
logic                     tdo;
logic                     tdo_en;
logic                     core_rst;
logic                     ndm_rst;

int check_errors = 0;
int timeouts     = 0;

// Debug module state as the testbench expects it
logic [dbg_pkg::XLEN-1:0] model_data0    = '0;
logic                     model_dmactive = 1'b0;
logic                     model_ndmreset = 1'b0;

tb_clkgen clkgen0 (
    .o_clk (clk)
);

core_top dut0 (
    .clk            (clk),
    .i_rst          (rst),
    .i_sys_rst      (sys_rst),
    .i_cpu_rst      (cpu_rst),
    .i_fuse_mhartid (fuse_mhartid),
    .i_fuse_idcode  (fuse_idcode),
    .i_tck          (tck),
    .i_tms          (tms),
    .i_tdi          (tdi),
    .o_tdo          (tdo),
    .o_tdo_en       (tdo_en),
    .o_core_rst     (core_rst),
    .o_ndm_rst      (ndm_rst)
);

// ----------------------------------------
// Compare tasks
// ----------------------------------------
task automatic check_data(input string name, input logic [dbg_pkg::XLEN-1:0] exp,
                          input logic [dbg_pkg::XLEN-1:0] act);
    if (act !== exp)
    begin
        check_errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_status(input string name, input dbg_pkg::dmi_op_e exp,
                            input dbg_pkg::dmi_op_e act);
    if (act !== exp)
    begin
        check_errors++;
        $display("CHECK FAILED %s: expected status %0d, actual status %0d", name, exp, act);
    end
endtask

task automatic check_line(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        check_errors++;
        $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
        check_errors++;
        $display("CHECK FAILED %s: expected %0d cycles, actual %0d cycles", name, exp, act);
    end
endtask

// ----------------------------------------
// Reference register map
// ----------------------------------------
function automatic logic [dbg_pkg::XLEN-1:0] expected_read(
    input logic [dbg_pkg::DMI_ADDR_W-1:0] addr);
    case (addr)
        dbg_pkg::DM_DATA0_ADDR:     return model_data0;
        dbg_pkg::DM_DMCONTROL_ADDR: return {30'b0, model_ndmreset, model_dmactive};
        dbg_pkg::DM_DMSTATUS_ADDR:  return dbg_pkg::DMSTATUS_VALUE;
        dbg_pkg::DM_HARTID_ADDR:    return fuse_mhartid;
        default:                    return '0;
    endcase
endfunction

function automatic void model_write(input logic [dbg_pkg::DMI_ADDR_W-1:0] addr,
                                    input logic [dbg_pkg::XLEN-1:0] data);
    if (addr == dbg_pkg::DM_DATA0_ADDR)
        model_data0 = data;
    else if (addr == dbg_pkg::DM_DMCONTROL_ADDR)
    begin
        model_dmactive = data[0];
        // ndmreset cannot survive dmactive going low
        model_ndmreset = data[0] & data[1];
    end
endfunction

// ----------------------------------------
// JTAG driver
// ----------------------------------------
task automatic step();
    @(posedge clk);
    #DRIVE_DELAY;
endtask

// One tck period: low half, tdo sampled, high half
task automatic tck_cycle(input logic tms_bit, input logic tdi_bit, output logic tdo_bit);
    tck = 1'b0;
    tms = tms_bit;
    tdi = tdi_bit;
    repeat (TCK_HALF) step();
    tdo_bit = tdo;
    tck = 1'b1;
    repeat (TCK_HALF) step();
endtask

task automatic tap_reset();
    logic tdo_bit;
    int   i;
    for (i = 0; i < 5; i++)
        tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
endtask

// Idle to Idle through the IR column
task automatic scan_ir(input logic [dbg_pkg::IR_W-1:0] ir);
    logic tdo_bit;
    int   i;
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    for (i = 0; i < dbg_pkg::IR_W; i++)
        tck_cycle(i == dbg_pkg::IR_W - 1, ir[i], tdo_bit);
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
endtask

// Idle to Idle through the DR column, LSB first
task automatic scan_dr(input logic [dbg_pkg::DMI_DR_W-1:0] din, input int len,
                       output logic [dbg_pkg::DMI_DR_W-1:0] dout);
    logic tdo_bit;
    int   i;
    dout = '0;
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    // Capture happens on this rise
    tck_cycle(1'b0, 1'b0, tdo_bit);
    check_line("shift-dr tdo_en", 1'b1, tdo_en);
    for (i = 0; i < len; i++)
    begin
        tck_cycle(i == len - 1, din[i], tdo_bit);
        dout[i] = tdo_bit;
    end
    check_line("exit1-dr tdo_en", 1'b0, tdo_en);
    tck_cycle(1'b1, 1'b0, tdo_bit);
    // Update on the fall of this one
    tck_cycle(1'b0, 1'b0, tdo_bit);
endtask

// ----------------------------------------
// DMI access over JTAG
// ----------------------------------------
task automatic scan_dmi_word(input dbg_pkg::dmi_op_e op,
                             input logic [dbg_pkg::DMI_ADDR_W-1:0] addr,
                             input logic [dbg_pkg::XLEN-1:0] data,
                             output dbg_pkg::dmi_op_e status,
                             output logic [dbg_pkg::XLEN-1:0] rdata);
    logic [dbg_pkg::DMI_DR_W-1:0] dout;
    scan_dr({addr, data, op}, dbg_pkg::DMI_DR_W, dout);
    status = dbg_pkg::dmi_op_e'(dout[dbg_pkg::DMI_OP_W-1:0]);
    rdata  = dout[dbg_pkg::DMI_DATA_LSB +: dbg_pkg::DMI_DATA_W];
endtask

task automatic poll_dmi_status(input string name, output dbg_pkg::dmi_op_e status,
                               output logic [dbg_pkg::XLEN-1:0] rdata);
    int tries;
    tries  = 0;
    status = dbg_pkg::DMI_STATUS_BUSY;
    rdata  = '0;
    while (status !== dbg_pkg::DMI_STATUS_OK && tries < POLL_LIMIT)
    begin
        scan_dmi_word(dbg_pkg::DMI_OP_NOP, '0, '0, status, rdata);
        tries++;
    end
    if (status !== dbg_pkg::DMI_STATUS_OK)
    begin
        timeouts++;
        $display("%s: DMI request still not done after %0d polls", name, POLL_LIMIT);
    end
endtask

task automatic write_dm_reg(input string name, input logic [dbg_pkg::DMI_ADDR_W-1:0] addr,
                            input logic [dbg_pkg::XLEN-1:0] data);
    dbg_pkg::dmi_op_e         status;
    logic [dbg_pkg::XLEN-1:0] rdata;
    model_write(addr, data);
    scan_dmi_word(dbg_pkg::DMI_OP_WRITE, addr, data, status, rdata);
    check_status({name, " issue"}, dbg_pkg::DMI_STATUS_OK, status);
    poll_dmi_status(name, status, rdata);
    check_status({name, " done"}, dbg_pkg::DMI_STATUS_OK, status);
endtask

task automatic read_dm_reg(input string name, input logic [dbg_pkg::DMI_ADDR_W-1:0] addr,
                           output logic [dbg_pkg::XLEN-1:0] rdata,
                           output dbg_pkg::dmi_op_e status);
    dbg_pkg::dmi_op_e         issue_status;
    logic [dbg_pkg::XLEN-1:0] old_data;
    scan_dmi_word(dbg_pkg::DMI_OP_READ, addr, '0, issue_status, old_data);
    check_status({name, " issue"}, dbg_pkg::DMI_STATUS_OK, issue_status);
    poll_dmi_status(name, status, rdata);
endtask

// Reads one register and compares data and status with the model
task automatic verify_dm_reg(input string name, input logic [dbg_pkg::DMI_ADDR_W-1:0] addr);
    logic [dbg_pkg::XLEN-1:0] rdata;
    dbg_pkg::dmi_op_e         status;
    read_dm_reg(name, addr, rdata, status);
    check_data(name, expected_read(addr), rdata);
    check_status(name, dbg_pkg::DMI_STATUS_OK, status);
endtask

// ----------------------------------------
// Reset timing
// ----------------------------------------
task automatic measure_rst_release(input string name);
    int cycles;
    cycles = 0;
    while (core_rst !== 1'b0 && cycles < RST_LIMIT)
    begin
        step();
        cycles++;
    end
    if (core_rst !== 1'b0)
    begin
        timeouts++;
        $display("%s: o_core_rst still high after %0d cycles", name, RST_LIMIT);
    end
    else
        check_count(name, dbg_pkg::CORE_RST_HOLD, cycles);
endtask

task automatic wait_ndm_fall(input string name);
    int cycles;
    cycles = 0;
    while (ndm_rst !== 1'b0 && cycles < NDM_LIMIT)
    begin
        step();
        cycles++;
    end
    if (ndm_rst !== 1'b0)
    begin
        timeouts++;
        $display("%s: o_ndm_rst did not fall within %0d cycles", name, NDM_LIMIT);
    end
    else
        measure_rst_release(name);
endtask

task automatic pulse_reset_input(input string name, input bit use_cpu);
    check_line({name, " idle"}, 1'b0, core_rst);
    if (use_cpu)
        cpu_rst = 1'b1;
    else
        sys_rst = 1'b1;
    step();
    check_line({name, " asserted"}, 1'b1, core_rst);
    repeat (2) step();
    cpu_rst = 1'b0;
    sys_rst = 1'b0;
    measure_rst_release({name, " release"});
endtask

// ----------------------------------------
// Test sequence
// ----------------------------------------
initial
begin
    logic [dbg_pkg::DMI_DR_W-1:0] dout;
    logic [dbg_pkg::XLEN-1:0]     pattern;
    int                           i;
    int                           total;

    void'($urandom(SEED));
    fuse_idcode  = $urandom() | 32'h1;
    fuse_mhartid = $urandom();
    rst          = 1'b1;
    sys_rst      = 1'b0;
    cpu_rst      = 1'b0;
    tck          = 1'b0;
    tms          = 1'b1;
    tdi          = 1'b0;

    // Power-up reset
    step();
    check_line("reset core_rst", 1'b1, core_rst);
    check_line("reset tdo_en", 1'b0, tdo_en);
    check_line("reset ndm_rst", 1'b0, ndm_rst);
    step();
    rst = 1'b0;
    measure_rst_release("rst release");

    // IDCODE comes back after a TAP reset, then BYPASS
    tap_reset();
    scan_ir(dbg_pkg::IR_DMI);
    tap_reset();
    scan_dr('0, dbg_pkg::XLEN, dout);
    check_data("idcode", fuse_idcode, dout[dbg_pkg::XLEN-1:0]);
    scan_ir(dbg_pkg::IR_BYPASS);
    pattern = $urandom();
    scan_dr(dbg_pkg::DMI_DR_W'(pattern), dbg_pkg::XLEN, dout);
    check_data("bypass", {pattern[dbg_pkg::XLEN-2:0], 1'b0}, dout[dbg_pkg::XLEN-1:0]);

    // Register map through DMI
    scan_ir(dbg_pkg::IR_DMI);
    for (i = 0; i < 4; i++)
    begin
        write_dm_reg("data0 write", dbg_pkg::DM_DATA0_ADDR, $urandom());
        verify_dm_reg("data0 read", dbg_pkg::DM_DATA0_ADDR);
    end
    verify_dm_reg("hartid read", dbg_pkg::DM_HARTID_ADDR);
    verify_dm_reg("dmstatus read", dbg_pkg::DM_DMSTATUS_ADDR);
    write_dm_reg("unmapped write", UNMAPPED_ADDR, $urandom());
    verify_dm_reg("unmapped read", UNMAPPED_ADDR);

    // ndmreset through dmcontrol
    write_dm_reg("ndmreset on", dbg_pkg::DM_DMCONTROL_ADDR, 32'h3);
    check_line("ndmreset on ndm_rst", model_ndmreset, ndm_rst);
    check_line("ndmreset on core_rst", 1'b1, core_rst);
    verify_dm_reg("dmcontrol read on", dbg_pkg::DM_DMCONTROL_ADDR);
    fork
        write_dm_reg("ndmreset off", dbg_pkg::DM_DMCONTROL_ADDR, 32'h1);
        wait_ndm_fall("ndmreset off release");
    join
    check_line("ndmreset off ndm_rst", model_ndmreset, ndm_rst);
    verify_dm_reg("dmcontrol read off", dbg_pkg::DM_DMCONTROL_ADDR);

    // Other reset sources
    pulse_reset_input("cpu_rst pulse", 1'b1);
    pulse_reset_input("sys_rst pulse", 1'b0);

    total = check_errors + timeouts + dut0.i_core_top_asserts.fail_cnt;
    $display("Error counts: %0d check, %0d timeout, %0d assertion",
             check_errors, timeouts, dut0.i_core_top_asserts.fail_cnt);
    if (total == 0)
        $display("test passed");
    else
        $display("test failed");
    $finish;
end

endmodule : tb_core_top

`default_nettype wire

// ==== list.f ====
common/dbg_pkg.sv
common/dmi_if.sv
tapc/jtag_sampler.sv
tapc/tap_ctrl.sv
dm/debug_module.sv
hdl/reset_ctrl.sv
hdl/core_top.sv
verif/core_top_asserts.sv
verif/tb_clkgen.sv
verif/tb_core_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the core_top testbench with Verilator and runs it.
# Exit status is 0 only when the pass message is printed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core_top -f list.f -o sim_tb_core_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_core_top +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1
